/* all.f */
hw/bpred_pkg.sv
hw/sat_counter_table.sv
hw/global_history.sv
hw/bpred_update.sv
hw/tournament_bpred.sv
sim/bpred_props.sv
sim/tb_bpred.sv

/* Makefile */
# Verilator build and run of the tournament predictor testbench

VERILATOR ?= verilator
TOP       ?= tb_bpred
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_bpred.sv */
/*
  Testbench for the tournament predictor; a cycle model runs beside the DUT.
  Inputs change on the falling edge, outputs are compared on the falling edge.
  Resolution metadata is taken from the DUT's own prediction outputs.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_bpred import bpred_pkg::*; ();

	// Test lengths in clock cycles
	localparam int RESET_CYCLES = 16;
	localparam int ALT_ROUNDS = 40;
	localparam int RAND_CYCLES = 2000;
	// Sum of reset, alternating rounds at four cycles each, random stream and directed tests
	localparam int TEST_CYCLES = RESET_CYCLES + 4 * ALT_ROUNDS + RAND_CYCLES + 64;
	localparam int LIMIT = 2 * TEST_CYCLES;

	// Metadata the pipeline keeps with a branch
	typedef struct packed {
		logic                 taken;
		logic                 glob;
		logic                 loc;
		logic                 choice;
		logic [BP_HIST_W-1:0] hist;
	} meta_t;

	logic clk, i_reset, i_pred_valid, i_res_valid, i_res_taken;
	logic i_res_global, i_res_local, i_res_choice;
	logic [BP_PC_W-1:0] i_pred_pc, i_res_pc;
	logic [BP_HIST_W-1:0] i_res_hist, o_pred_hist;
	logic o_pred_valid, o_pred_taken, o_pred_global, o_pred_local, o_pred_choice;
	logic o_mispredict;

	// Model state
	int m_loc [BP_ENTRIES];
	int m_glb [BP_ENTRIES];
	int m_cho [BP_ENTRIES];
	int m_ls, m_gs, m_cs;
	logic [BP_HIST_W-1:0] m_spec, m_commit, m_hist, r_h;
	logic m_pv, m_misp, r_v, r_t, r_g, r_l, r_c;
	logic [BP_PC_W-1:0] r_pc;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	tournament_bpred dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Counter states as plain integers 0 to 3
	function automatic int ctr_step(input int s, input logic up);
		if (up) return (s == 3) ? 3 : s + 1;
		return (s == 0) ? 0 : s - 1;
	endfunction

	function automatic logic ctr_taken(input int s);
		return s >= 2;
	endfunction

	// Final prediction from the three counter states
	function automatic logic ref_pred(input int ls, input int gs, input int cs);
		return ctr_taken(cs) ? ctr_taken(gs) : ctr_taken(ls);
	endfunction

	// One clock edge of the reference model
	task automatic model_step();
		logic [BP_INDEX_W-1:0] ridx, pidx;
		logic [BP_HIST_W-1:0] commit_n, spec_n;
		logic misp;
		if (i_reset) begin
			for (int i = 0; i < BP_ENTRIES; i++) begin
				m_loc[i] = 1;
				m_glb[i] = 1;
				m_cho[i] = 1;
			end
			{m_ls, m_gs, m_cs} = {32'd1, 32'd1, 32'd1};
			{m_spec, m_commit, m_hist} = '0;
			{m_pv, m_misp, r_v} = 3'b000;
			return;
		end
		// Resolution registered at the previous edge acts now
		ridx = r_pc[BP_PC_LSB +: BP_INDEX_W];
		misp = r_v && ((r_c ? r_g : r_l) != r_t);
		commit_n = r_v ? {m_commit[BP_HIST_W-2:0], r_t} : m_commit;
		// Restore beats the shift by the visible prediction
		if (misp) spec_n = commit_n;
		else if (m_pv) spec_n = {m_spec[BP_HIST_W-2:0], ref_pred(m_ls, m_gs, m_cs)};
		else spec_n = m_spec;
		// Reads see the tables before this edge's update
		if (i_pred_valid) begin
			pidx = i_pred_pc[BP_PC_LSB +: BP_INDEX_W];
			m_ls = m_loc[pidx];
			m_gs = m_glb[pidx ^ spec_n];
			m_cs = m_cho[pidx];
			m_hist = spec_n;
		end
		m_pv = i_pred_valid;
		if (r_v) begin
			m_loc[ridx] = ctr_step(m_loc[ridx], r_t);
			m_glb[ridx ^ r_h] = ctr_step(m_glb[ridx ^ r_h], r_t);
			// Choice learns only from a disagreement
			if (r_g != r_l) m_cho[ridx] = ctr_step(m_cho[ridx], r_g == r_t);
		end
		m_spec = spec_n;
		m_commit = commit_n;
		m_misp = misp;
		r_v = i_res_valid;
		if (i_res_valid) begin
			{r_pc, r_t, r_h} = {i_res_pc, i_res_taken, i_res_hist};
			{r_g, r_l, r_c} = {i_res_global, i_res_local, i_res_choice};
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_hist(input string name, input logic [BP_HIST_W-1:0] got,
			input logic [BP_HIST_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	initial forever begin
		@(posedge clk);
		model_step();
	end

	// Every output against the model in every cycle out of reset
	initial forever begin
		@(negedge clk);
		if (!i_reset) begin
			check_bit("o_pred_valid", o_pred_valid, m_pv);
			check_bit("o_mispredict", o_mispredict, m_misp);
			check_bit("o_pred_local", o_pred_local, ctr_taken(m_ls));
			check_bit("o_pred_global", o_pred_global, ctr_taken(m_gs));
			check_bit("o_pred_choice", o_pred_choice, ctr_taken(m_cs));
			check_bit("o_pred_taken", o_pred_taken, ref_pred(m_ls, m_gs, m_cs));
			check_hist("o_pred_hist", o_pred_hist, m_hist);
		end
	end

	// Cycle limit for the whole run
	initial begin
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Run stopped: cycle limit %0d reached before the tests ended", LIMIT);
		$display(">>> FAIL");
		$finish;
	end

	task automatic predict(input logic [BP_PC_W-1:0] pc, output meta_t m);
		@(negedge clk);
		i_pred_valid = 1'b1;
		i_pred_pc = pc;
		@(negedge clk);
		i_pred_valid = 1'b0;
		while (!o_pred_valid) @(negedge clk);
		m = {o_pred_taken, o_pred_global, o_pred_local, o_pred_choice, o_pred_hist};
	endtask

	// Returns on the falling edge after the resolution was sampled
	task automatic resolve(input logic [BP_PC_W-1:0] pc, input logic taken, input meta_t m);
		@(negedge clk);
		{i_res_valid, i_res_pc, i_res_taken, i_res_hist} = {1'b1, pc, taken, m.hist};
		{i_res_global, i_res_local, i_res_choice} = {m.glob, m.loc, m.choice};
		@(negedge clk);
		i_res_valid = 1'b0;
	endtask

	// Waits past the falling edge so that its compares are counted
	task automatic report(input int num, input string name, input int err_before);
		@(posedge clk);
		$display("test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "errors");
	endtask

	initial begin
		meta_t m, q_m[$], mb[4], eb[4];
		logic [BP_PC_W-1:0] q_pc[$], last_pc, pc;
		logic [BP_HIST_W-1:0] exp_hist;
		logic seen_choice;
		int e0;
		void'($urandom(32'h382a78ab));
		{i_reset, i_pred_valid, i_res_valid, i_res_taken} = 4'b1000;
		{i_res_global, i_res_local, i_res_choice} = 3'b000;
		{i_pred_pc, i_res_pc, i_res_hist, last_pc} = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		i_reset = 1'b0;

		e0 = errors;
		predict(32'h100, m);
		check_bit("o_pred_taken", m.taken, 1'b0);
		check_bit("o_pred_choice", m.choice, 1'b0);
		check_hist("o_pred_hist", m.hist, '0);
		report(1, "reset state", e0);

		// First resolution of an always taken branch mispredicts
		e0 = errors;
		predict(32'h200, m);
		resolve(32'h200, 1'b1, m);
		check_bit("o_mispredict", o_mispredict, 1'b0);
		@(negedge clk);
		check_bit("o_mispredict", o_mispredict, 1'b1);
		predict(32'h200, m);
		resolve(32'h200, 1'b1, m);
		predict(32'h200, m);
		check_bit("o_pred_local", m.loc, 1'b1);
		check_bit("o_pred_taken", m.taken, 1'b1);
		report(2, "local learning", e0);

		// Alternating outcomes, even rounds not taken
		e0 = errors;
		seen_choice = 1'b0;
		for (int k = 0; k < ALT_ROUNDS; k++) begin
			predict(32'h300, m);
			seen_choice |= m.choice;
			resolve(32'h300, 1'(k), m);
		end
		if (!seen_choice) begin
			errors++;
			$display("Alternating branch never switched the choice to global");
		end
		report(3, "gshare learning", e0);

		// Back-to-back requests give one result per cycle
		e0 = errors;
		for (int k = 0; k < 5; k++) begin
			@(negedge clk);
			if (k > 0) begin
				mb[k-1] = {o_pred_taken, o_pred_global, o_pred_local,
					o_pred_choice, o_pred_hist};
				// Model view of the same result
				eb[k-1] = {ref_pred(m_ls, m_gs, m_cs), ctr_taken(m_gs), ctr_taken(m_ls),
					ctr_taken(m_cs), m_hist};
			end
			i_pred_valid = (k < 4);
			i_pred_pc = 32'h400 + 32'(k * 4);
		end
		// Each request indexed with the history shifted by the one before it
		for (int k = 0; k < 3; k++) begin
			check_hist("o_pred_hist", mb[k+1].hist,
				{eb[k].hist[BP_HIST_W-2:0], eb[k].taken});
		end
		// Opposite outcome forces a restore from the committed history
		exp_hist = {m_commit[BP_HIST_W-2:0], !eb[3].taken};
		resolve(32'h40c, !eb[3].taken, mb[3]);
		predict(32'h500, m);
		check_hist("o_pred_hist", m.hist, exp_hist);
		report(4, "speculative history", e0);

		// Random stream over 16 PCs, oldest prediction resolved first
		e0 = errors;
		for (int k = 0; k < RAND_CYCLES; k++) begin
			@(negedge clk);
			if (o_pred_valid) begin
				q_m.push_back({o_pred_taken, o_pred_global, o_pred_local,
					o_pred_choice, o_pred_hist});
				q_pc.push_back(last_pc);
			end
			last_pc = 32'h1000 + 32'(($urandom() % 16) * 4);
			i_pred_valid = 1'($urandom());
			i_pred_pc = last_pc;
			i_res_valid = 1'b0;
			if (q_m.size() > 0 && 1'($urandom())) begin
				m = q_m.pop_front();
				pc = q_pc.pop_front();
				{i_res_valid, i_res_pc} = {1'b1, pc};
				{i_res_taken, i_res_hist} = {1'($urandom()), m.hist};
				{i_res_global, i_res_local, i_res_choice} = {m.glob, m.loc, m.choice};
			end
		end
		@(negedge clk);
		{i_pred_valid, i_res_valid} = 2'b00;
		repeat (3) @(negedge clk);
		report(5, "random stream", e0);

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim/bpred_props.sv */
/*
  Protocol properties of the predictor top level, bound into every instance.
  Resolution history is looked at up to three cycles back.
*/
`timescale 1ns/1ps
`default_nettype none

module bpred_props (
	input wire logic clk,
	input wire logic i_reset,
	input wire logic i_pred_valid,
	input wire logic o_pred_valid,
	input wire logic i_res_valid,
	input wire logic o_mispredict
);

	// Result valid is the request delayed by exactly one cycle
	assert property (@(posedge clk) disable iff (i_reset)
		o_pred_valid == $past(i_pred_valid))
		else $error("o_pred_valid does not follow i_pred_valid");

	// Two pulses in a row need two resolutions in a row
	assert property (@(posedge clk) disable iff (i_reset)
		(o_mispredict && $past(o_mispredict)) |-> ($past(i_res_valid, 2) && $past(i_res_valid, 3)))
		else $error("back-to-back mispredict without back-to-back resolutions");

	// Synchronous reset clears both strobes one edge later
	assert property (@(posedge clk)
		(i_reset && $past(i_reset)) |-> (!o_pred_valid && !o_mispredict))
		else $error("strobes active during reset");

endmodule

bind tournament_bpred bpred_props props_i (
	.clk          (clk),
	.i_reset      (i_reset),
	.i_pred_valid (i_pred_valid),
	.o_pred_valid (o_pred_valid),
	.i_res_valid  (i_res_valid),
	.o_mispredict (o_mispredict)
);

`default_nettype wire

/* hw/tournament_bpred.sv */
/*
  Tournament direction predictor: local table, gshare table and choice table.
  Results appear one cycle after a request, one per cycle, no back-pressure.
  The pipeline must return hist, global, local and choice with each resolution.
*/
`timescale 1ns/1ps
`default_nettype none

module tournament_bpred import bpred_pkg::*; (
	input  wire logic                 clk,
	input  wire logic                 i_reset,

	// Prediction request
	input  wire logic                 i_pred_valid,
	input  wire logic [BP_PC_W-1:0]   i_pred_pc,

	// Prediction result, one cycle after the request
	output logic                      o_pred_valid,
	output logic                      o_pred_taken,
	output logic                      o_pred_global,
	output logic                      o_pred_local,
	output logic      [BP_HIST_W-1:0] o_pred_hist,
	output logic                      o_pred_choice,

	// Resolution with the metadata from prediction time
	input  wire logic                 i_res_valid,
	input  wire logic [BP_PC_W-1:0]   i_res_pc,
	input  wire logic                 i_res_taken,
	input  wire logic [BP_HIST_W-1:0] i_res_hist,
	input  wire logic                 i_res_global,
	input  wire logic                 i_res_local,
	input  wire logic                 i_res_choice,

	output logic                      o_mispredict
);

	logic [BP_HIST_W-1:0]  spec_hist;
	logic [BP_INDEX_W-1:0] pc_idx;
	logic [BP_INDEX_W-1:0] gshare_idx;

	sat_state_e local_state;
	sat_state_e global_state;
	sat_state_e choice_state;

	logic                  local_upd_en;
	logic [BP_INDEX_W-1:0] local_upd_idx;
	logic                  global_upd_en;
	logic [BP_INDEX_W-1:0] global_upd_idx;
	logic                  upd_up;
	logic                  choice_upd_en;
	logic [BP_INDEX_W-1:0] choice_upd_idx;
	logic                  choice_up;
	logic                  commit;
	logic                  restore;

	// Read indexes
	assign pc_idx     = i_pred_pc[BP_PC_LSB +: BP_INDEX_W];
	assign gshare_idx = pc_idx ^ spec_hist;

	sat_counter_table u_local_tbl (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_rd_en    (i_pred_valid),
		.i_rd_idx   (pc_idx),
		.o_rd_state (local_state),
		.i_upd_en   (local_upd_en),
		.i_upd_idx  (local_upd_idx),
		.i_upd_up   (upd_up)
	);

	sat_counter_table u_global_tbl (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_rd_en    (i_pred_valid),
		.i_rd_idx   (gshare_idx),
		.o_rd_state (global_state),
		.i_upd_en   (global_upd_en),
		.i_upd_idx  (global_upd_idx),
		.i_upd_up   (upd_up)
	);

	// Choice shares the local index
	sat_counter_table u_choice_tbl (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_rd_en    (i_pred_valid),
		.i_rd_idx   (pc_idx),
		.o_rd_state (choice_state),
		.i_upd_en   (choice_upd_en),
		.i_upd_idx  (choice_upd_idx),
		.i_upd_up   (choice_up)
	);

	// Each valid prediction shifts the speculative history at the next edge
	global_history u_history (
		.clk          (clk),
		.i_reset      (i_reset),
		.i_spec_shift (o_pred_valid),
		.i_spec_bit   (o_pred_taken),
		.i_commit     (commit),
		.i_commit_bit (upd_up),
		.i_restore    (restore),
		.o_spec_hist  (spec_hist)
	);

	bpred_update u_update (
		.clk              (clk),
		.i_reset          (i_reset),
		.i_res_valid      (i_res_valid),
		.i_res_pc         (i_res_pc),
		.i_res_taken      (i_res_taken),
		.i_res_hist       (i_res_hist),
		.i_res_global     (i_res_global),
		.i_res_local      (i_res_local),
		.i_res_choice     (i_res_choice),
		.o_local_upd_en   (local_upd_en),
		.o_local_upd_idx  (local_upd_idx),
		.o_global_upd_en  (global_upd_en),
		.o_global_upd_idx (global_upd_idx),
		.o_upd_up         (upd_up),
		.o_choice_upd_en  (choice_upd_en),
		.o_choice_upd_idx (choice_upd_idx),
		.o_choice_up      (choice_up),
		.o_commit         (commit),
		.o_restore        (restore),
		.o_mispredict     (o_mispredict)
	);

	// Valid and the indexing history line up with the registered table reads
	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_pred_valid <= 1'b0;
			o_pred_hist  <= '0;
		end else begin
			o_pred_valid <= i_pred_valid;
			if (i_pred_valid) begin
				o_pred_hist <= spec_hist;
			end
		end
	end

	// Component predictions and the final pick
	assign o_pred_local  = sat_taken(local_state);
	assign o_pred_global = sat_taken(global_state);
	assign o_pred_choice = sat_taken(choice_state);
	assign o_pred_taken  = o_pred_choice ? o_pred_global : o_pred_local;

endmodule

`default_nettype wire

/* hw/bpred_update.sv */
/*
  Resolution stage: one register on the returned branch, then update commands.
  Indexes are rebuilt from the returned PC and history, so the caller must hand
  back exactly the metadata captured at prediction time.
  The choice table is indexed by PC bits, the same as the local table.
*/
`timescale 1ns/1ps
`default_nettype none

module bpred_update import bpred_pkg::*; (
	input  wire logic                  clk,
	input  wire logic                  i_reset,

	// Resolved branch with its prediction metadata
	input  wire logic                  i_res_valid,
	input  wire logic [BP_PC_W-1:0]    i_res_pc,
	input  wire logic                  i_res_taken,
	input  wire logic [BP_HIST_W-1:0]  i_res_hist,
	input  wire logic                  i_res_global,
	input  wire logic                  i_res_local,
	input  wire logic                  i_res_choice,

	// Component table training, both move toward the actual outcome
	output logic                       o_local_upd_en,
	output logic      [BP_INDEX_W-1:0] o_local_upd_idx,
	output logic                       o_global_upd_en,
	output logic      [BP_INDEX_W-1:0] o_global_upd_idx,
	output logic                       o_upd_up,

	// Choice training
	output logic                       o_choice_upd_en,
	output logic      [BP_INDEX_W-1:0] o_choice_upd_idx,
	output logic                       o_choice_up,

	// History control
	output logic                       o_commit,
	output logic                       o_restore,

	output logic                       o_mispredict
);

	// Control part of the stage register
	logic                  valid_q;
	logic                  mispredict_q;

	// Payload part, qualified by valid_q
	logic [BP_PC_W-1:0]    pc_q;
	logic                  taken_q;
	logic [BP_HIST_W-1:0]  hist_q;
	logic                  global_q;
	logic                  local_q;
	logic                  choice_q;

	logic [BP_INDEX_W-1:0] pc_idx;
	logic                  final_pred;
	logic                  mispred;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= i_res_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (i_res_valid) begin
			pc_q     <= i_res_pc;
			taken_q  <= i_res_taken;
			hist_q   <= i_res_hist;
			global_q <= i_res_global;
			local_q  <= i_res_local;
			choice_q <= i_res_choice;
		end
	end

	// Same index bits as the prediction side
	assign pc_idx = pc_q[BP_PC_LSB +: BP_INDEX_W];

	assign o_local_upd_en   = valid_q;
	assign o_local_upd_idx  = pc_idx;
	assign o_global_upd_en  = valid_q;
	assign o_global_upd_idx = pc_idx ^ hist_q;
	assign o_upd_up         = taken_q;

	// Only a disagreement says anything about which component is better
	assign o_choice_upd_en  = valid_q && (global_q != local_q);
	assign o_choice_upd_idx = pc_idx;
	assign o_choice_up      = (global_q == taken_q);

	// Final prediction as it was made, from the returned choice bit
	assign final_pred = choice_q ? global_q : local_q;
	assign mispred    = valid_q && (final_pred != taken_q);

	// Every resolved branch enters the committed history
	assign o_commit  = valid_q;
	assign o_restore = mispred;

	// Pulse one cycle after the tables are written
	always_ff @(posedge clk) begin
		if (i_reset) begin
			mispredict_q <= 1'b0;
		end else begin
			mispredict_q <= mispred;
		end
	end

	assign o_mispredict = mispredict_q;

endmodule

`default_nettype wire

/* hw/global_history.sv */
/*
  Speculative and committed global history, newest outcome at bit 0.
  o_spec_hist is the value the speculative register takes at the next edge,
  so a request in the cycle after a prediction or a restore already sees it.
  A restore wins over a speculative shift in the same cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module global_history import bpred_pkg::*; (
	input  wire logic                 clk,
	input  wire logic                 i_reset,

	// Shift by the prediction made this cycle
	input  wire logic                 i_spec_shift,
	input  wire logic                 i_spec_bit,

	// Shift by a resolved branch
	input  wire logic                 i_commit,
	input  wire logic                 i_commit_bit,

	// Misprediction, copy committed history into the speculative one
	input  wire logic                 i_restore,

	output logic      [BP_HIST_W-1:0] o_spec_hist
);

	logic [BP_HIST_W-1:0] spec_q;
	logic [BP_HIST_W-1:0] commit_q;
	logic [BP_HIST_W-1:0] commit_next;
	logic [BP_HIST_W-1:0] spec_next;

	// Committed history including this cycle's resolution
	always_comb begin
		commit_next = commit_q;
		if (i_commit) begin
			commit_next = {commit_q[BP_HIST_W-2:0], i_commit_bit};
		end
	end

	// Restore takes the updated committed value
	// so the resolving branch's own outcome is kept
	always_comb begin
		if (i_restore) begin
			spec_next = commit_next;
		end else if (i_spec_shift) begin
			spec_next = {spec_q[BP_HIST_W-2:0], i_spec_bit};
		end else begin
			spec_next = spec_q;
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			spec_q   <= '0;
			commit_q <= '0;
		end else begin
			spec_q   <= spec_next;
			commit_q <= commit_next;
		end
	end

	// Forward the pending value to the index logic
	assign o_spec_hist = spec_next;

endmodule

`default_nettype wire

/* hw/sat_counter_table.sv */
/*
  Table of 2-bit saturating counters, one registered read port, one update port.
  All entries return to weak not taken in the single reset cycle.
  A read and an update of the same index in one cycle return the old state.
*/
`timescale 1ns/1ps
`default_nettype none

module sat_counter_table import bpred_pkg::*; (
	input  wire logic                  clk,
	input  wire logic                  i_reset,

	// Read port, result registered for the next cycle
	input  wire logic                  i_rd_en,
	input  wire logic [BP_INDEX_W-1:0] i_rd_idx,
	output sat_state_e                 o_rd_state,

	// Update port, one step per strobe
	input  wire logic                  i_upd_en,
	input  wire logic [BP_INDEX_W-1:0] i_upd_idx,
	input  wire logic                  i_upd_up
);

	// Counter storage
	sat_state_e counters [BP_ENTRIES];

	// Next value of the counter under update
	sat_state_e upd_next;

	assign upd_next = sat_next(counters[i_upd_idx], i_upd_up);

	// Whole table is cleared at once, so no sweep is needed after reset
	always_ff @(posedge clk) begin
		if (i_reset) begin
			for (int i = 0; i < BP_ENTRIES; i++) begin
				counters[i] <= st_weak_nt;
			end
		end else if (i_upd_en) begin
			counters[i_upd_idx] <= upd_next;
		end
	end

	// Registered read
	// sees the array before this edge's update, so same index gives old state
	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_rd_state <= st_weak_nt;
		end else if (i_rd_en) begin
			o_rd_state <= counters[i_rd_idx];
		end
	end

endmodule

`default_nettype wire

/* hw/bpred_pkg.sv */
/*
  Shared sizes, counter encoding and counter helpers for the tournament predictor.
  All tables share one index width, and the history width must equal it so the
  gshare XOR covers the whole index. PCs are word aligned.
*/
`default_nettype none

package bpred_pkg;

	// Core data path width, only the PC is used here
	localparam int BP_PC_W = 32;

	// Index width of every table
	localparam int BP_INDEX_W = 10;
	localparam int BP_ENTRIES = 1 << BP_INDEX_W;

	// Global history length, equal to the index width for a full gshare XOR
	localparam int BP_HIST_W = 10;

	// Bits [1:0] of a word aligned PC carry no information
	localparam int BP_PC_LSB = 2;

	// 2-bit saturating counter, weak not taken is the reset value
	typedef enum logic [1:0] {
		st_strong_nt = 2'd0,
		st_weak_nt   = 2'd1,
		st_weak_t    = 2'd2,
		st_strong_t  = 2'd3
	} sat_state_e;

	// Upper half of the range means taken
	function automatic logic sat_taken(input sat_state_e state);
		return (state == st_weak_t) || (state == st_strong_t);
	endfunction

	// One step toward taken when up is set, toward not taken otherwise
	function automatic sat_state_e sat_next(input sat_state_e state, input logic up);
		sat_state_e nxt;
		nxt = state;
		case (state)
			st_strong_nt: nxt = up ? st_weak_nt : st_strong_nt;
			st_weak_nt:   nxt = up ? st_weak_t : st_strong_nt;
			st_weak_t:    nxt = up ? st_strong_t : st_weak_nt;
			st_strong_t:  nxt = up ? st_strong_t : st_weak_t;
			default:      nxt = st_weak_nt;
		endcase
		return nxt;
	endfunction

endpackage

`default_nettype wire
